// File: logic/rob_pkg.sv
`default_nettype none

package rob_pkg;

    // Number of reorder slots, which is also the number of tags in flight
    localparam int N_ROB_ENTRIES = 16;

    // Width of the data word carried by each response
    localparam int ROB_DATA_BITS = 32;

    // Extra output register stages behind the RAM read register
    localparam int RAM_OUT_STAGES = 1;

    // Cycles from a drain read until its data leaves the RAM
    // The first cycle is the RAM read register itself
    localparam int RAM_RD_LATENCY = 1 + RAM_OUT_STAGES;

    // Bits needed to name one slot
    localparam int ROB_TAG_BITS = $clog2(N_ROB_ENTRIES);

    // Slot index handed out with each request and returned with its response
    typedef logic [ROB_TAG_BITS-1:0] rob_tag_t;

    // Occupancy needs one more bit than a tag so a full buffer can be counted
    typedef logic [ROB_TAG_BITS:0] rob_count_t;

    // Response payload
    typedef logic [ROB_DATA_BITS-1:0] rob_data_t;

    // One response as it arrives from the memory side
    typedef struct packed
    {
        rob_tag_t  tag;
        rob_data_t data;
    } rob_rsp_t;

endpackage

`default_nettype wire

// File: logic/rob_dualport_ram.sv
`timescale 1ns/1ps
`default_nettype none

// Simple dual-port block RAM
// Port 1 only writes and port 0 only reads
// A read of an address that is written in the same cycle returns the old word
module rob_dualport_ram
#(
    parameter int N_ENTRIES = 16,
    parameter int N_DATA_BITS = 32,
    // Extra register stages after the read register
    parameter int N_OUTPUT_REG_STAGES = 0
)
(
    input  wire logic                         clk0,
    input  wire logic [$clog2(N_ENTRIES)-1:0] addr0,
    output logic      [N_DATA_BITS-1:0]       rdata0,
    input  wire logic [$clog2(N_ENTRIES)-1:0] addr1,
    input  wire logic                         wen1,
    input  wire logic [N_DATA_BITS-1:0]       wdata1
);

    // Storage array
    logic [N_DATA_BITS-1:0] mem [0:N_ENTRIES-1];

    // Read pipeline, where stage 0 is the RAM read register
    logic [N_DATA_BITS-1:0] rd_pipe [0:N_OUTPUT_REG_STAGES];

    // Both ports share one block so the read sees the word before this edge's write
    always_ff @(posedge clk0)
    begin
        if (wen1)
        begin
            mem[addr1] <= wdata1;
        end
        rd_pipe[0] <= mem[addr0];
    end

    // Optional output registers to ease timing out of the block RAM
    genvar s;
    generate
        for (s = 0; s < N_OUTPUT_REG_STAGES; s = s + 1)
        begin : g_out_reg
            always_ff @(posedge clk0)
            begin
                rd_pipe[s+1] <= rd_pipe[s];
            end
        end
    endgenerate

    // Data leaves from the last stage of the pipeline
    assign rdata0 = rd_pipe[N_OUTPUT_REG_STAGES];

endmodule

`default_nettype wire

// File: logic/rob_tag_alloc.sv
`timescale 1ns/1ps
`default_nettype none

// Tag allocator for the reorder buffer
// Tags go out in sequence and wrap around the slot count
module rob_tag_alloc
(
    input  wire logic              clk0,
    input  wire logic              rst,
    input  wire logic              alloc_req,
    input  wire logic              drain_fire,
    output rob_pkg::rob_tag_t      alloc_tag,
    output logic                   full
);

    import rob_pkg::*;

    // Next slot to hand out
    rob_tag_t head_ptr;

    // Slots allocated and not yet drained
    rob_count_t occupancy;

    // A request while full is dropped
    logic alloc_ok;

    assign alloc_ok = alloc_req && !full;

    // The head pointer is visible as the tag in the same cycle as the request
    assign alloc_tag = head_ptr;

    // Full follows the registered count and so lags the edge by one cycle
    assign full = (occupancy == rob_count_t'(N_ROB_ENTRIES));

    // The tag width matches the slot count so the pointer wraps on its own
    always_ff @(posedge clk0)
    begin
        if (rst)
        begin
            head_ptr <= '0;
        end
        else if (alloc_ok)
        begin
            head_ptr <= head_ptr + rob_tag_t'(1);
        end
    end

    // Occupancy rises on an allocation and falls on a drain
    // When both happen together the count holds
    always_ff @(posedge clk0)
    begin
        if (rst)
        begin
            occupancy <= '0;
        end
        else
        begin
            case ({alloc_ok, drain_fire})
                2'b10:
                    occupancy <= occupancy + rob_count_t'(1);
                2'b01:
                    occupancy <= occupancy - rob_count_t'(1);
                default:
                    occupancy <= occupancy;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: logic/rob_fill.sv
`timescale 1ns/1ps
`default_nettype none

// Response fill for the reorder buffer
// Each response is written into the RAM at its tag and its slot is marked valid
module rob_fill
(
    input  wire logic                                clk0,
    input  wire logic                                rst,
    input  wire logic                                rsp_valid,
    input  wire rob_pkg::rob_rsp_t                   rsp,
    input  wire logic                                drain_fire,
    input  wire rob_pkg::rob_tag_t                   drain_tag,
    output logic [rob_pkg::N_ROB_ENTRIES-1:0]        entry_valid,
    output logic                                     ram_wen,
    output rob_pkg::rob_tag_t                        ram_waddr,
    output rob_pkg::rob_data_t                       ram_wdata
);

    // The tag of a response is its slot address in the RAM
    assign ram_wen   = rsp_valid;
    assign ram_waddr = rsp.tag;
    assign ram_wdata = rsp.data;

    // One valid bit per slot
    // The bit is set on the same edge that writes the RAM, so the drain side
    // sees it one cycle later, when the written word can already be read
    always_ff @(posedge clk0)
    begin
        if (rst)
        begin
            entry_valid <= '0;
        end
        else
        begin
            // Drained slot is released here
            if (drain_fire)
            begin
                entry_valid[drain_tag] <= 1'b0;
            end

            // A fresh response to a slot that was drained and reallocated
            // in the same cycle must not be lost, so set is written last
            if (rsp_valid)
            begin
                entry_valid[rsp.tag] <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/rob_drain.sv
`timescale 1ns/1ps
`default_nettype none

// In-order drain for the reorder buffer
// The tail slot leaves as soon as its response has arrived
module rob_drain
(
    input  wire logic                                clk0,
    input  wire logic                                rst,
    input  wire logic [rob_pkg::N_ROB_ENTRIES-1:0]   entry_valid,
    output logic                                     drain_fire,
    output rob_pkg::rob_tag_t                        drain_tag,
    input  wire rob_pkg::rob_data_t                  ram_rdata,
    output logic                                     out_valid,
    output rob_pkg::rob_data_t                       out_data
);

    import rob_pkg::*;

    // Oldest slot still waiting to leave
    rob_tag_t tail_ptr;

    // Strobes for reads in flight through the RAM, one bit per cycle of latency
    logic [RAM_RD_LATENCY-1:0] rd_pending;

    // Fire whenever the oldest response is present
    // Nothing waits behind the output, so one slot leaves per cycle at most
    assign drain_fire = entry_valid[tail_ptr];

    // The tail pointer also addresses the RAM read port
    assign drain_tag = tail_ptr;

    // Walk through the slots in allocation order
    always_ff @(posedge clk0)
    begin
        if (rst)
        begin
            tail_ptr <= '0;
        end
        else if (drain_fire)
        begin
            tail_ptr <= tail_ptr + rob_tag_t'(1);
        end
    end

    // Delay the drain strobe by the RAM read latency
    // The RAM read register captures on the drain edge, so stage 0 matches it
    always_ff @(posedge clk0)
    begin
        if (rst)
        begin
            rd_pending <= '0;
        end
        else
        begin
            rd_pending[0] <= drain_fire;
            for (int i = 1; i < RAM_RD_LATENCY; i++)
            begin
                rd_pending[i] <= rd_pending[i-1];
            end
        end
    end

    // Strobe and data line up at the last stage
    assign out_valid = rd_pending[RAM_RD_LATENCY-1];
    // RAM output registers already hold the word, no extra capture here
    assign out_data = ram_rdata;

endmodule

`default_nettype wire

// File: logic/rob_top.sv
`timescale 1ns/1ps
`default_nettype none

// Response reorder buffer
// Out-of-order responses are parked by tag and released in allocation order
module rob_top
(
    input  wire logic                 clk0,
    input  wire logic                 rst,
    input  wire logic                 alloc_req,
    output rob_pkg::rob_tag_t         alloc_tag,
    output logic                      full,
    input  wire logic                 rsp_valid,
    input  wire rob_pkg::rob_rsp_t    rsp,
    output logic                      out_valid,
    output rob_pkg::rob_data_t        out_data
);

    import rob_pkg::*;

    // Drain events go back to the allocator and the valid bits
    logic     drain_fire;
    rob_tag_t drain_tag;

    // Per-slot valid bits from fill to drain
    logic [N_ROB_ENTRIES-1:0] entry_valid;

    // RAM write and read data paths
    logic      ram_wen;
    rob_tag_t  ram_waddr;
    rob_data_t ram_wdata;
    rob_data_t ram_rdata;

    // Input side
    rob_tag_alloc u_alloc
    (
        .clk0       (clk0),
        .rst        (rst),
        .alloc_req  (alloc_req),
        .drain_fire (drain_fire),
        .alloc_tag  (alloc_tag),
        .full       (full)
    );

    // Response fill and slot tracking
    rob_fill u_fill
    (
        .clk0        (clk0),
        .rst         (rst),
        .rsp_valid   (rsp_valid),
        .rsp         (rsp),
        .drain_fire  (drain_fire),
        .drain_tag   (drain_tag),
        .entry_valid (entry_valid),
        .ram_wen     (ram_wen),
        .ram_waddr   (ram_waddr),
        .ram_wdata   (ram_wdata)
    );

    // Response storage, written by fill and read by drain
    rob_dualport_ram
    #(
        .N_ENTRIES           (N_ROB_ENTRIES),
        .N_DATA_BITS         (ROB_DATA_BITS),
        .N_OUTPUT_REG_STAGES (RAM_OUT_STAGES)
    )
    u_ram
    (
        .clk0   (clk0),
        .addr0  (drain_tag),
        .rdata0 (ram_rdata),
        .addr1  (ram_waddr),
        .wen1   (ram_wen),
        .wdata1 (ram_wdata)
    );

    // Output side
    rob_drain u_drain
    (
        .clk0        (clk0),
        .rst         (rst),
        .entry_valid (entry_valid),
        .drain_fire  (drain_fire),
        .drain_tag   (drain_tag),
        .ram_rdata   (ram_rdata),
        .out_valid   (out_valid),
        .out_data    (out_data)
    );

endmodule

`default_nettype wire

// File: testbench/rob_tb.sv
`timescale 1ns/1ps
`default_nettype none

// Directed testbench for the response reorder buffer
// Expected words are recorded at allocation time, so the output order is checked
// against allocation order and not against the order in which responses were sent
module rob_tb;

    import rob_pkg::*;

    localparam int CLK_PERIOD = 10;
    localparam int RESET_CYCLES = 16;
    // One cycle for the registered valid bit, then two cycles through the RAM
    localparam int RSP_TO_OUT = 3;
    // Rough sum of all test lengths in cycles, reset included
    localparam int TEST_CYCLES = 300;
    // Longest wait for outstanding outputs before giving up
    localparam int OUT_WAIT = 64;

    logic      clk0;
    logic      rst;
    logic      alloc_req;
    rob_tag_t  alloc_tag;
    logic      full;
    logic      rsp_valid;
    rob_rsp_t  rsp;
    logic      out_valid;
    rob_data_t out_data;

    integer seed;
    int     errors;
    int     tests_run;
    int     tests_bad;
    int     cycle = 0;

    // Model of the allocator head pointer and a running allocation number
    rob_tag_t next_tag;
    int       alloc_seq;

    // Expected words in allocation order and words seen on the output
    rob_data_t exp_q[$];
    rob_data_t rcv_q[$];
    int        rcv_cycle[$];

    // Allocated tags that still wait for their response
    rob_tag_t  pend_tag[$];
    rob_data_t pend_data[$];

    rob_top uut
    (
        .clk0      (clk0),
        .rst       (rst),
        .alloc_req (alloc_req),
        .alloc_tag (alloc_tag),
        .full      (full),
        .rsp_valid (rsp_valid),
        .rsp       (rsp),
        .out_valid (out_valid),
        .out_data  (out_data)
    );

    initial
    begin
        clk0 = 1'b0;
        forever #(CLK_PERIOD / 2) clk0 = ~clk0;
    end

    // Cycle count used to measure output latency
    always @(posedge clk0)
    begin
        cycle <= cycle + 1;
    end

    // Outputs are registered, so the falling edge sees them settled
    always @(negedge clk0)
    begin
        if (!rst && out_valid)
        begin
            rcv_q.push_back(out_data);
            rcv_cycle.push_back(cycle);
        end
    end

    // Ends the run if the tests hang, with a fourfold margin on their length
    initial
    begin
        #(TEST_CYCLES * CLK_PERIOD * 4);
        $display("Watchdog expired at cycle %0d, the tests did not finish", cycle);
        $display("Test failed");
        $finish;
    end

    // Inputs change 1 ns after the rising edge
    task automatic tick();
        @(posedge clk0);
        #1;
    endtask

    // Test number in the top byte keeps words of different tests apart
    function automatic rob_data_t make_data(input int test_num, input int seq,
                                            input rob_tag_t tag);
        return {test_num[7:0], 4'h0, seq[15:0], tag};
    endfunction

    // One alloc_req cycle checked against the modeled head pointer and full flag
    // The caller knows from the test sequence whether the buffer has room
    task automatic alloc_one(input int test_num, input bit expect_ok);
        rob_data_t d;
        alloc_req = 1'b1;
        if (alloc_tag !== next_tag)
        begin
            $display("FAIL alloc_tag: got %h expected %h", alloc_tag, next_tag);
            errors++;
        end
        if (full !== !expect_ok)
        begin
            $display("FAIL full: got %h expected %h", full, !expect_ok);
            errors++;
        end
        if (expect_ok)
        begin
            d = make_data(test_num, alloc_seq, next_tag);
            exp_q.push_back(d);
            pend_tag.push_back(next_tag);
            pend_data.push_back(d);
            next_tag++;
            alloc_seq++;
        end
        tick();
        alloc_req = 1'b0;
    endtask

    // Allocation that must succeed because the buffer is not full
    task automatic alloc_expect(input int test_num);
        alloc_one(test_num, 1'b1);
    endtask

    task automatic send_rsp(input rob_tag_t tag, input rob_data_t data);
        rsp_valid = 1'b1;
        rsp.tag = tag;
        rsp.data = data;
        tick();
        rsp_valid = 1'b0;
    endtask

    // Fisher-Yates shuffle of the waiting responses
    task automatic shuffle_pending();
        int        j;
        rob_tag_t  t;
        rob_data_t d;
        for (int i = pend_tag.size() - 1; i > 0; i--)
        begin
            j = $unsigned($random(seed)) % (i + 1);
            t = pend_tag[i];
            d = pend_data[i];
            pend_tag[i] = pend_tag[j];
            pend_data[i] = pend_data[j];
            pend_tag[j] = t;
            pend_data[j] = d;
        end
    endtask

    task automatic send_pending();
        for (int i = 0; i < pend_tag.size(); i++)
        begin
            send_rsp(pend_tag[i], pend_data[i]);
        end
        pend_tag.delete();
        pend_data.delete();
    endtask

    task automatic wait_outputs(input int n);
        int waited;
        waited = 0;
        while (rcv_q.size() < n && waited < OUT_WAIT)
        begin
            tick();
            waited++;
        end
        if (rcv_q.size() < n)
        begin
            $display("Only %0d of %0d outputs arrived in time", rcv_q.size(), n);
            errors++;
        end
    endtask

    // Compares all outputs with the allocation order, then looks for extra words
    task automatic check_outputs();
        int n;
        wait_outputs(exp_q.size());
        repeat (8) tick();
        if (rcv_q.size() != exp_q.size())
        begin
            $display("FAIL output count: got %h expected %h", rcv_q.size(), exp_q.size());
            errors++;
        end
        n = (rcv_q.size() < exp_q.size()) ? rcv_q.size() : exp_q.size();
        for (int i = 0; i < n; i++)
        begin
            if (rcv_q[i] !== exp_q[i])
            begin
                $display("FAIL out_data[%0d]: got %h expected %h", i, rcv_q[i], exp_q[i]);
                errors++;
            end
        end
        exp_q.delete();
        rcv_q.delete();
        rcv_cycle.delete();
    endtask

    task automatic finish_test(input string name, input int start_errors);
        tests_run++;
        if (errors == start_errors)
        begin
            $display("[%s] passed", name);
        end
        else
        begin
            tests_bad++;
            $display("[%s] %0d errors", name, errors - start_errors);
        end
    endtask

    task automatic test_reset();
        int e0;
        e0 = errors;
        if (out_valid !== 1'b0)
        begin
            $display("FAIL out_valid: got %h expected %h", out_valid, 1'b0);
            errors++;
        end
        if (full !== 1'b0)
        begin
            $display("FAIL full: got %h expected %h", full, 1'b0);
            errors++;
        end
        if (alloc_tag !== '0)
        begin
            $display("FAIL alloc_tag: got %h expected %h", alloc_tag, 4'h0);
            errors++;
        end
        repeat (20) tick();
        if (rcv_q.size() != 0)
        begin
            $display("An output appeared although no response was sent");
            errors++;
        end
        finish_test("reset", e0);
    endtask

    task automatic test_in_order();
        int e0;
        int first_cycle;
        e0 = errors;
        repeat (4) alloc_expect(2);
        first_cycle = cycle;
        send_pending();
        wait_outputs(1);
        if (rcv_cycle.size() > 0 && rcv_cycle[0] - first_cycle != RSP_TO_OUT)
        begin
            $display("FAIL first output latency: got %h expected %h",
                     rcv_cycle[0] - first_cycle, RSP_TO_OUT);
            errors++;
        end
        check_outputs();
        finish_test("in_order", e0);
    endtask

    task automatic test_reverse();
        int e0;
        e0 = errors;
        repeat (8) alloc_expect(3);
        // Every tag except the head is answered, newest first
        for (int i = 7; i > 0; i--)
        begin
            send_rsp(pend_tag[i], pend_data[i]);
        end
        repeat (RSP_TO_OUT + 2) tick();
        if (rcv_q.size() != 0)
        begin
            $display("An output appeared before the head tag was answered");
            errors++;
        end
        send_rsp(pend_tag[0], pend_data[0]);
        pend_tag.delete();
        pend_data.delete();
        check_outputs();
        finish_test("reverse", e0);
    endtask

    task automatic test_fill_full();
        int e0;
        e0 = errors;
        repeat (N_ROB_ENTRIES) alloc_expect(4);
        // All slots are taken, so full must be up and this request must be dropped
        // The model head stays put
        alloc_one(4, 1'b0);
        if (alloc_tag !== next_tag)
        begin
            $display("FAIL alloc_tag: got %h expected %h", alloc_tag, next_tag);
            errors++;
        end
        shuffle_pending();
        send_pending();
        check_outputs();
        if (full !== 1'b0)
        begin
            $display("FAIL full: got %h expected %h", full, 1'b0);
            errors++;
        end
        finish_test("fill_full", e0);
    endtask

    // Small groups keep occupancy well below full while the tags wrap
    task automatic test_stream();
        int e0;
        int total;
        int k;
        e0 = errors;
        total = 0;
        while (total < 40)
        begin
            k = 1 + ($unsigned($random(seed)) % 6);
            if (k > 40 - total)
            begin
                k = 40 - total;
            end
            repeat (k) alloc_expect(5);
            shuffle_pending();
            send_pending();
            total += k;
        end
        check_outputs();
        finish_test("stream", e0);
    endtask

    initial
    begin
        seed = 32'h79ee_8003;
        rst = 1'b1;
        alloc_req = 1'b0;
        rsp_valid = 1'b0;
        rsp = '0;
        errors = 0;
        tests_run = 0;
        tests_bad = 0;
        next_tag = '0;
        alloc_seq = 0;
        repeat (RESET_CYCLES) @(posedge clk0);
        #1;
        rst = 1'b0;

        test_reset();
        test_in_order();
        test_reverse();
        test_fill_full();
        test_stream();

        $display("Summary: %0d tests run, %0d with errors, %0d failed checks",
                 tests_run, tests_bad, errors);
        if (errors == 0)
        begin
            $display("Test completed successfully");
        end
        else
        begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: project.f
logic/rob_pkg.sv
logic/rob_dualport_ram.sv
logic/rob_tag_alloc.sv
logic/rob_fill.sv
logic/rob_drain.sv
logic/rob_top.sv
testbench/rob_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the reorder buffer testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -f project.f --top-module rob_tb -o rob_sim

./obj_dir/rob_sim > sim.log 2>&1
cat sim.log

# The testbench prints the fail message on any error or timeout
if grep -q "Test failed" sim.log; then
    echo "Simulation reported a failure"
    exit 1
fi

echo "Simulation finished without failure"
exit 0
